//--- hypot_defs.svh
`ifndef HYPOT_DEFS_SVH
`define HYPOT_DEFS_SVH

// Operand side, fixed by the 8-bit pins
`define HYP_OPND_W      8
`define HYP_SQ_W        16          // One operand squared

// Sum of two squares, 255^2 + 255^2 = 130050 needs 17 bits
`define HYP_SUM_W       17

// Root of a 17-bit value, up to 360
`define HYP_ROOT_W      9
`define HYP_OUT_W       8           // Saturated byte on uo_out
`define HYP_OUT_MAX     255

// Restoring square root sequencing
`define HYP_ROOT_ITERS  9           // Candidate bits 16, 14, ... 0
`define HYP_CNT_W       4           // Wide enough for the iteration count

// Highest power of four below 2^17
`define HYP_BIT_INIT    17'h1_0000

`endif

//--- hypot_io_pkg.sv
`include "hypot_defs.svh"

package hypot_io_pkg;

    // Operand pair as it arrives from the pins
    // x from ui_in, y from uio_in
    typedef struct packed {
        logic [`HYP_OPND_W-1:0] x;      // Upper byte
        logic [`HYP_OPND_W-1:0] y;      // Lower byte
    } hyp_operands_t;

    // Magnitude byte after saturation
    typedef logic [`HYP_OUT_W-1:0] hyp_out_t;

endpackage

//--- hypot_calc_pkg.sv
`include "hypot_defs.svh"

package hypot_calc_pkg;

    // x^2 + y^2, full width
    typedef logic [`HYP_SUM_W-1:0] hyp_sum_t;

    // Unsaturated root
    typedef logic [`HYP_ROOT_W-1:0] hyp_root_t;

    // Root sequencer states
    typedef enum logic [1:0] {
        LOAD    = 2'd0,     // Latch new sum
        ITER    = 2'd1,     // One candidate bit per cycle
        PUBLISH = 2'd2      // Drive result byte
    } hyp_root_state_e;

    // Working record of the shift-and-subtract root
    // part and cand kept at sum width so the trial add lines up with rem
    typedef struct packed {
        hyp_sum_t               rem;    // Remainder still to be covered
        hyp_sum_t               part;   // Partial root, scaled
        hyp_sum_t               cand;   // Current candidate bit, power of four
        logic [`HYP_CNT_W-1:0]  cnt;    // Iterations done this round
    } hyp_root_work_t;

endpackage

//--- hypot_square_sum.sv
`timescale 1ns/1ps

`include "hypot_defs.svh"

// Square both operands, then add
// Two registered stages, flowing continuously while ena is high
module hypot_square_sum
    import hypot_io_pkg::*;
    import hypot_calc_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          ena,
    input  hyp_operands_t operands,
    output hyp_sum_t      sum_sq
);

    // Stage 1, squares of x and y
    logic [`HYP_SQ_W-1:0] sq_x;
    logic [`HYP_SQ_W-1:0] sq_y;

    // Stage 2 input, carry kept in the extra bit
    hyp_sum_t sum_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sq_x <= '0;
            sq_y <= '0;
        end else if (ena) begin
            sq_x <= operands.x * operands.x;    // 8x8 -> 16
            sq_y <= operands.y * operands.y;
        end
    end

    // Zero-extend both before the add so the carry survives
    assign sum_d = {1'b0, sq_x} + {1'b0, sq_y};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_sq <= '0;
        end else if (ena) begin
            sum_sq <= sum_d;                    // One edge behind the squares
        end
    end

endmodule

//--- hypot_isqrt.sv
`timescale 1ns/1ps

`include "hypot_defs.svh"

// Restoring integer square root, one candidate bit per cycle
// Fixed round of LOAD, 9 x ITER, PUBLISH = 11 enabled cycles
module hypot_isqrt
    import hypot_io_pkg::*;
    import hypot_calc_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     ena,
    input  hyp_sum_t sum_sq,
    output hyp_out_t magnitude
);

    hyp_root_state_e state_q;
    hyp_root_state_e state_d;

    hyp_root_work_t  work_q;
    hyp_root_work_t  work_d;

    // Trial subtrahend, one bit wider than the sum so the add cannot wrap
    logic [`HYP_SUM_W:0] trial;
    logic                fits;          // Remainder covers the trial

    // Final root and its saturated byte
    hyp_root_t root;
    hyp_out_t  root_sat;

    assign trial = {1'b0, work_q.part} + {1'b0, work_q.cand};
    assign fits  = ({1'b0, work_q.rem} >= trial);

    // After the last iteration part holds the plain root
    assign root = work_q.part[`HYP_ROOT_W-1:0];

    // Clamp 256..360 down to the top of the byte
    always_comb begin
        if (root > `HYP_OUT_MAX) begin
            root_sat = hyp_out_t'(`HYP_OUT_MAX);
        end else begin
            root_sat = root[`HYP_OUT_W-1:0];
        end
    end

    // Next state and next working record
    always_comb begin
        state_d = state_q;
        work_d  = work_q;

        case (state_q)
            LOAD: begin
                work_d.rem  = sum_sq;               // Snapshot of the front stage
                work_d.part = '0;
                work_d.cand = `HYP_BIT_INIT;        // Always start from bit 16
                work_d.cnt  = '0;
                state_d     = ITER;
            end

            ITER: begin
                if (fits) begin
                    // Bit belongs to the root
                    work_d.rem  = work_q.rem - trial[`HYP_SUM_W-1:0];
                    work_d.part = (work_q.part >> 1) + work_q.cand;
                end else begin
                    work_d.part = work_q.part >> 1; // Bit stays clear
                end

                work_d.cand = work_q.cand >> 2;     // Next power of four down
                work_d.cnt  = work_q.cnt + 1'b1;

                // Last candidate is bit 0
                if (work_q.cnt == `HYP_CNT_W'(`HYP_ROOT_ITERS - 1)) begin
                    state_d = PUBLISH;
                end
            end

            PUBLISH: begin
                state_d = LOAD;                     // Straight into next round
            end

            default: begin
                state_d = LOAD;
            end
        endcase
    end

    // Sequencer and working record
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= LOAD;
            work_q  <= '0;
        end else if (ena) begin
            state_q <= state_d;
            work_q  <= work_d;
        end
    end

    // Output byte, only touched on PUBLISH edges
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            magnitude <= '0;
        end else if (ena && (state_q == PUBLISH)) begin
            magnitude <= root_sat;
        end
    end

endmodule

//--- hypot_top.sv
`timescale 1ns/1ps

`include "hypot_defs.svh"

// Vector magnitude on Tiny Tapeout style pins
// uo_out = min(255, isqrt(ui_in^2 + uio_in^2))
module hypot_top
    import hypot_io_pkg::*;
    import hypot_calc_pkg::*;
(
    input  logic [`HYP_OPND_W-1:0] ui_in,   // Operand x
    input  logic [`HYP_OPND_W-1:0] uio_in,  // Operand y
    output logic [7:0]             uo_out,  // Saturated root
    output logic [7:0]             uio_out,
    output logic [7:0]             uio_oe,
    input  logic                   ena,     // Level, low freezes everything
    input  logic                   clk,
    input  logic                   rst_n
);

    hyp_operands_t operands;
    hyp_sum_t      sum_sq;
    hyp_out_t      magnitude;

    // Pin bytes into the operand pair
    assign operands.x = ui_in;
    assign operands.y = uio_in;

    // Front stage, squares then sum
    hypot_square_sum u_square_sum (
        .clk      (clk),
        .rst_n    (rst_n),
        .ena      (ena),
        .operands (operands),
        .sum_sq   (sum_sq)
    );

    // Root sequencer with saturating output register
    hypot_isqrt u_isqrt (
        .clk       (clk),
        .rst_n     (rst_n),
        .ena       (ena),
        .sum_sq    (sum_sq),
        .magnitude (magnitude)
    );

    assign uo_out  = magnitude;

    // Bidirectional pins used as inputs only
    assign uio_out = '0;
    assign uio_oe  = '0;                    // All input

endmodule

//--- tb_hypot_top.sv
`timescale 1ns/1ps

`include "hypot_defs.svh"

// Self-checking testbench for the vector magnitude unit
module tb_hypot_top
    import hypot_io_pkg::*;
    import hypot_calc_pkg::*;
();

    localparam int WAIT_LIMIT    = 30;  // Timeout of every wait, in cycles
    localparam int SETTLE_MAX    = 24;  // 2 front + 2 full root rounds
    localparam int ROUND_CYCLES  = 11;  // LOAD, 9 x ITER, PUBLISH
    localparam int FREEZE_CYCLES = 30;
    localparam int RANDOM_PAIRS  = 40;

    logic       clk;
    logic       rst_n;
    logic       ena;
    logic [7:0] ui_in;
    logic [7:0] uio_in;
    logic [7:0] uo_out;
    logic [7:0] uio_out;
    logic [7:0] uio_oe;

    logic [15:0] lfsr_q;                // Random source state

    hypot_top uut (
        .ui_in   (ui_in),
        .uio_in  (uio_in),
        .uo_out  (uo_out),
        .uio_out (uio_out),
        .uio_oe  (uio_oe),
        .ena     (ena),
        .clk     (clk),
        .rst_n   (rst_n)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Bidirectional pins never driven
    assert property (@(posedge clk) (uio_out == 8'h00) && (uio_oe == 8'h00))
        else begin
            $display("uio_out or uio_oe went nonzero at time %0t", $time);
            $display("Test failed");
            $fatal(1, "unused IO driven");
        end

    // Wrong value seen by a check
    task automatic report_mismatch(input string name, input hyp_out_t expected,
                                   input hyp_out_t actual);
        $display("Error: %s expected %0d actual %0d", name, expected, actual);
        $display("Test failed");
        $fatal(1, "value mismatch");
    endtask

    // Any failure other than a wrong value
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "check failed");
    endtask

    // Rising edge, then a little margin for driving and sampling
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic drive_operands(input hyp_operands_t pair);
        ui_in  = pair.x;
        uio_in = pair.y;
    endtask

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    // One LFSR step per bit taken
    task automatic draw_byte(output logic [7:0] b);
        b = '0;
        for (int i = 0; i < 8; i++) begin
            b      = {b[6:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    // Floor root by trying every candidate, then clamp to a byte
    function automatic hyp_out_t expected_magnitude(input hyp_operands_t pair);
        int        sum;
        hyp_root_t root;
        sum  = int'(pair.x) * int'(pair.x) + int'(pair.y) * int'(pair.y);
        root = '0;
        for (int c = 0; c <= 360; c++) begin
            if (c * c <= sum) begin
                root = hyp_root_t'(c);
            end
        end
        if (int'(root) > `HYP_OUT_MAX) begin
            return hyp_out_t'(`HYP_OUT_MAX);
        end
        return root[7:0];
    endfunction

    // Wait until uo_out shows exp, bounded by WAIT_LIMIT
    task automatic wait_for_byte(input string name, input hyp_out_t exp, output int cycles);
        int n;
        bit seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < WAIT_LIMIT) begin
            tick();
            n++;
            seen = (uo_out == exp);
        end
        assert (seen)
            else report_failure($sformatf("Wait for %s expired after %0d cycles",
                                          name, WAIT_LIMIT));
        assert (n <= SETTLE_MAX)
            else report_failure($sformatf("%s took %0d cycles, over the %0d cycle bound",
                                          name, n, SETTLE_MAX));
        cycles = n;
    endtask

    // uo_out must not move for a number of cycles
    task automatic hold_check(input string name, input hyp_out_t exp, input int len);
        for (int i = 0; i < len; i++) begin
            tick();
            assert (uo_out == exp) else report_mismatch(name, exp, uo_out);
        end
    endtask

    // Directed pair, result must arrive and then survive one round
    task automatic check_pair(input string name, input logic [7:0] x, input logic [7:0] y,
                              input hyp_out_t exp);
        hyp_operands_t pair;
        int            cycles;
        pair.x = x;
        pair.y = y;
        assert (expected_magnitude(pair) == exp)                // Model agrees
            else report_mismatch({name, " model"}, exp, expected_magnitude(pair));
        drive_operands(pair);
        wait_for_byte(name, exp, cycles);
        hold_check({name, " hold"}, exp, ROUND_CYCLES);
    endtask

    initial begin
        hyp_operands_t pair;
        hyp_out_t      exp;
        int            cycles;
        string         name;

        ui_in  = '0;
        uio_in = '0;
        ena    = 1'b0;
        rst_n  = 1'b0;
        lfsr_q = 16'd83;

        // Outputs idle during reset
        repeat (3) begin
            tick();
            assert (uo_out == 8'h00) else report_mismatch("reset uo_out", 8'h00, uo_out);
            assert (uio_out == 8'h00) else report_mismatch("reset uio_out", 8'h00, uio_out);
            assert (uio_oe == 8'h00) else report_mismatch("reset uio_oe", 8'h00, uio_oe);
        end
        rst_n = 1'b1;
        ena   = 1'b1;
        tick();
        assert (uo_out == 8'h00) else report_mismatch("post reset uo_out", 8'h00, uo_out);
        assert (uio_out == 8'h00) else report_mismatch("post reset uio_out", 8'h00, uio_out);
        assert (uio_oe == 8'h00) else report_mismatch("post reset uio_oe", 8'h00, uio_oe);

        // Directed magnitudes
        check_pair("pair 3 4", 8'd3, 8'd4, 8'd5);
        check_pair("pair 0 0", 8'd0, 8'd0, 8'd0);
        check_pair("pair 180 0", 8'd180, 8'd0, 8'd180);
        check_pair("pair 0 255", 8'd0, 8'd255, 8'd255);
        check_pair("pair 120 160", 8'd120, 8'd160, 8'd200);

        // Roots of 282 and 360 clamp to 255
        check_pair("sat 200 200", 8'd200, 8'd200, 8'd255);
        check_pair("pair 6 8", 8'd6, 8'd8, 8'd10);              // Move off 255 first
        check_pair("sat 255 255", 8'd255, 8'd255, 8'd255);

        // LFSR pairs, 16 steps each
        for (int i = 0; i < RANDOM_PAIRS; i++) begin
            draw_byte(pair.x);
            draw_byte(pair.y);
            exp  = expected_magnitude(pair);
            name = $sformatf("random %0d (%0d,%0d)", i, pair.x, pair.y);
            drive_operands(pair);
            wait_for_byte(name, exp, cycles);
            repeat (SETTLE_MAX - cycles) tick();                // Let any late round pass
            assert (uo_out == exp) else report_mismatch(name, exp, uo_out);
        end

        // Enable low freezes the old result
        check_pair("freeze base", 8'd30, 8'd40, 8'd50);
        ena    = 1'b0;
        pair.x = 8'd100;
        pair.y = 8'd75;
        exp    = expected_magnitude(pair);
        assert (exp == 8'd125) else report_mismatch("freeze model", 8'd125, exp);
        drive_operands(pair);
        hold_check("freeze hold", 8'd50, FREEZE_CYCLES);
        ena = 1'b1;
        wait_for_byte("freeze release", exp, cycles);

        $display("Test passed");
        $finish;
    end

endmodule

//--- hypot_top.f
+incdir+.
hypot_io_pkg.sv
hypot_calc_pkg.sv
hypot_square_sum.sv
hypot_isqrt.sv
hypot_top.sv
tb_hypot_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the hypot_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_hypot_top \
    -f hypot_top.f \
    -o sim_hypot

# A fatal stop exits nonzero, the grep below decides the result
sim_out=$(./obj_dir/sim_hypot 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "Test passed"; then
    exit 0
else
    echo "Simulation did not report a pass"
    exit 1
fi
